// File: verilog.f
design/i2c_pkg.sv
design/i2c_shift_if.sv
design/i2c_quarter_timer.sv
design/i2c_byte_shifter.sv
design/i2c_sequencer.sv
design/i2c_master_top.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_master

sources:
  - design/i2c_pkg.sv
  - design/i2c_shift_if.sv
  - design/i2c_quarter_timer.sv
  - design/i2c_byte_shifter.sv
  - design/i2c_sequencer.sv
  - design/i2c_master_top.sv
  - target: test
    files:
      - bench/i2c_slave_model.sv
      - bench/tb_i2c_master.sv

// File: bench/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master
    import i2c_pkg::*;
();

    localparam logic [6:0] SLAVE_ADDR = 7'h50;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TXN      = 16;                       // 15 transfers + final idle window
    localparam int LONGEST_Q    = QUARTERS_START + 5 * QUARTERS_BYTE + 2 * QUARTERS_SHORT;
    localparam int TXN_CYCLES   = LONGEST_Q * QUARTER_DIV;  // 16-bit read

    typedef struct packed {
        logic  err;
        logic  rd;
        byte_t data;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        i2c_exec;
    logic        i2c_rh_wl;
    logic        bit_ctrl;
    logic [6:0]  sensor_addr;
    logic [15:0] i2c_addr;
    byte_t       i2c_data_w;
    byte_t       i2c_data_r;
    logic        i2c_done;
    logic        err_flag;
    logic        scl;
    wire         sda;

    byte_t          shadow [0:65535];
    logic [65535:0] shadow_vld   = '0;
    expect_t        exp_q [$];
    int             issued_cnt   = 0;
    int             finished_cnt = 0;
    int             check_cnt    = 0;
    int             error_cnt    = 0;
    int             last_errors  = 0;
    integer         seed;

    pullup (sda);

    i2c_master_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i2c_exec    (i2c_exec),
        .i2c_rh_wl   (i2c_rh_wl),
        .bit_ctrl    (bit_ctrl),
        .sensor_addr (sensor_addr),
        .i2c_addr    (i2c_addr),
        .i2c_data_w  (i2c_data_w),
        .i2c_data_r  (i2c_data_r),
        .i2c_done    (i2c_done),
        .err_flag    (err_flag),
        .scl         (scl),
        .sda         (sda)
    );

    i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) i_slave (
        .scl    (scl),
        .sda    (sda),
        .addr16 (bit_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // last byte written, or the untouched-register pattern
    function automatic byte_t ref_read(input logic [15:0] addr);
        if (shadow_vld[addr])
            return shadow[addr];
        return addr[7:0] ^ 8'ha5;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        check_cnt = check_cnt + 1;
        if (got !== want) begin
            $display("[ERROR] %s: expected %0h, got %0h", name, want, got);
            error_cnt = error_cnt + 1;
        end
    endtask

    task automatic report_test(input string name);
        $display("%-24s %s, %0d errors", name,
                 (error_cnt == last_errors) ? "ok" : "FAILED", error_cnt - last_errors);
        last_errors = error_cnt;
    endtask

    // ============================================================
    // transfers
    // ============================================================
    task automatic issue_txn(input logic rd, input logic a16, input logic [6:0] dev,
                             input logic [15:0] addr, input byte_t wdata);
        logic [15:0] key;
        expect_t     want;
        key       = a16 ? addr : {8'h00, addr[7:0]};   // 8-bit mode has a zero high byte
        want.err  = (dev != SLAVE_ADDR);
        want.rd   = rd;
        want.data = ref_read(key);
        exp_q.push_back(want);
        if (!rd && !want.err) begin
            shadow[key]     = wdata;
            shadow_vld[key] = 1'b1;
        end
        @(negedge clk);
        i2c_rh_wl   = rd;
        bit_ctrl    = a16;
        sensor_addr = dev;
        i2c_addr    = addr;
        i2c_data_w  = wdata;
        i2c_exec    = 1'b1;
        issued_cnt  = issued_cnt + 1;
        @(negedge clk);
        i2c_exec = 1'b0;
    endtask

    task automatic wait_txn();
        int      cycles;
        expect_t lost;
        cycles = 0;
        while (finished_cnt != issued_cnt && cycles < 2 * TXN_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (finished_cnt != issued_cnt) begin
            $display("transfer %0d ended with neither i2c_done nor err_flag", issued_cnt);
            error_cnt    = error_cnt + 1;
            lost         = exp_q.pop_front();
            finished_cnt = issued_cnt;
        end
        repeat (4) @(negedge clk);                // bus idle gap
    endtask

    task automatic run_txn(input logic rd, input logic a16, input logic [6:0] dev,
                           input logic [15:0] addr, input byte_t wdata);
        issue_txn(rd, a16, dev, addr, wdata);
        wait_txn();
    endtask

    // ============================================================
    // response comparison
    // ============================================================
    initial begin : compare
        expect_t want;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && (i2c_done === 1'b1 || err_flag === 1'b1)) begin
                check_cnt = check_cnt + 1;
                if (i2c_done && err_flag) begin
                    $display("i2c_done and err_flag were high in the same cycle");
                    error_cnt = error_cnt + 1;
                end
                if (exp_q.size() == 0) begin
                    $display("%s pulse with no transfer outstanding",
                             i2c_done ? "i2c_done" : "err_flag");
                    error_cnt = error_cnt + 1;
                end else begin
                    want = exp_q.pop_front();
                    if (want.err && !err_flag) begin
                        $display("i2c_done where a missing acknowledge should give err_flag");
                        error_cnt = error_cnt + 1;
                    end else if (!want.err && !i2c_done) begin
                        $display("err_flag where the transfer should end with i2c_done");
                        error_cnt = error_cnt + 1;
                    end
                    @(negedge clk);                // read data one clock after done
                    if (i2c_done || err_flag) begin
                        $display("status pulse lasted longer than one cycle");
                        error_cnt = error_cnt + 1;
                    end
                    if (want.rd && !want.err)
                        check_value("i2c_data_r", i2c_data_r, want.data);
                    finished_cnt = finished_cnt + 1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + 2 * NUM_TXN * TXN_CYCLES) @(posedge clk);
        $display("watchdog expired, simulation stopped before all transfers finished");
        $display("Testbench failed");
        $finish;
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin : stimulus
        logic [15:0] addr;
        byte_t       data;
        seed        = 32'h4a3c_b816;
        rst_n       = 1'b0;
        i2c_exec    = 1'b0;
        i2c_rh_wl   = 1'b0;
        bit_ctrl    = 1'b0;
        sensor_addr = SLAVE_ADDR;
        i2c_addr    = '0;
        i2c_data_w  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("scl", scl, 1'b1);
        check_value("sda", sda, 1'b1);             // released and pulled up
        check_value("i2c_done", i2c_done, 1'b0);
        check_value("err_flag", err_flag, 1'b0);
        check_value("i2c_data_r", i2c_data_r, 8'h00);
        report_test("reset_state");

        run_txn(1'b0, 1'b0, SLAVE_ADDR, 16'h003c, 8'h5a);
        run_txn(1'b1, 1'b0, SLAVE_ADDR, 16'h003c, 8'h00);
        report_test("write_read_8bit");

        repeat (4) begin
            addr = 16'($random(seed));
            data = 8'($random(seed));
            run_txn(1'b0, 1'b1, SLAVE_ADDR, addr, data);
            run_txn(1'b1, 1'b1, SLAVE_ADDR, addr, 8'h00);
        end
        report_test("write_read_16bit");

        addr = 16'($random(seed));
        while (shadow_vld[addr])
            addr = addr + 1'b1;
        run_txn(1'b1, 1'b1, SLAVE_ADDR, addr, 8'h00);
        report_test("read_unwritten");

        run_txn(1'b0, 1'b1, SLAVE_ADDR ^ 7'h01, 16'h1234, 8'hc3);   // nobody answers
        run_txn(1'b1, 1'b1, SLAVE_ADDR, 16'h003c, 8'h00);   // 8-bit write seen at 16 bits
        report_test("nack_then_recover");

        run_txn(1'b0, 1'b1, SLAVE_ADDR, 16'h0a0b, 8'h96);
        issue_txn(1'b1, 1'b1, SLAVE_ADDR, 16'h0a0b, 8'h00);
        repeat (20 * QUARTER_DIV) @(negedge clk);
        i2c_addr   = 16'hbeef;                     // must not reach the bus
        i2c_data_w = 8'h11;
        i2c_exec   = 1'b1;
        @(negedge clk);
        i2c_exec = 1'b0;
        wait_txn();
        repeat (TXN_CYCLES) @(negedge clk);        // room for a second done
        report_test("exec_while_busy");

        $display("%0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model
    import i2c_pkg::*;
#(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  wire scl,
    inout  wire sda,
    input  wire addr16      // register address width of the running transfer
);

    typedef enum logic [2:0] {
        sl_idle, sl_dev, sl_reg_hi, sl_reg_lo, sl_wdata, sl_rdata
    } slave_phase_e;

    slave_phase_e   phase     = sl_idle;
    byte_t          mem [0:65535];
    logic [65535:0] vld       = '0;      // register written at least once
    byte_t          shreg     = '0;
    logic [15:0]    ptr       = '0;
    int             bit_cnt   = 0;
    logic           ack_slot  = 1'b0;
    logic           ack       = 1'b0;
    logic           is_read   = 1'b0;
    logic           drive_low = 1'b0;
    logic           scl_d     = 1'b1;
    logic           sda_d     = 1'b1;

    assign sda = drive_low ? 1'b0 : 1'bz;

    // ============================================================
    // scl falling edge where the device changes sda
    // ============================================================
    task automatic scl_fall();
        if (ack_slot) begin
            ack_slot  = 1'b0;
            bit_cnt   = 0;
            drive_low = 1'b0;                     // let go after the ack bit
            case (phase)
                sl_dev: begin
                    if (!ack) begin
                        phase = sl_idle;
                    end else if (is_read) begin
                        phase     = sl_rdata;
                        shreg     = vld[ptr] ? mem[ptr] : (ptr[7:0] ^ 8'ha5);
                        drive_low = !shreg[7];
                    end else begin
                        phase = addr16 ? sl_reg_hi : sl_reg_lo;
                    end
                end
                sl_reg_hi: phase = sl_reg_lo;
                sl_reg_lo: phase = sl_wdata;
                default:   phase = sl_idle;        // single byte per transfer
            endcase
        end else if (phase != sl_idle && bit_cnt == 8) begin
            ack_slot = 1'b1;
            ack      = 1'b1;
            case (phase)
                sl_dev: begin
                    ack     = (shreg[7:1] == DEV_ADDR);
                    is_read = shreg[0];
                end
                sl_reg_hi: ptr[15:8] = shreg;
                sl_reg_lo: ptr = addr16 ? {ptr[15:8], shreg} : {8'h00, shreg};
                sl_wdata: begin
                    mem[ptr] = shreg;
                    vld[ptr] = 1'b1;
                end
                default:   ack = 1'b0;             // master answers read data
            endcase
            drive_low = ack;
        end else if (phase == sl_rdata) begin
            drive_low = !shreg[7];                 // next read bit
        end
    endtask

    // ============================================================
    // bus watcher
    // ============================================================
    always @(scl or sda) begin
        if (scl_d === 1'b1 && scl === 1'b1 && sda_d === 1'b1 && sda === 1'b0) begin
            phase     = sl_dev;                    // start or repeated start
            bit_cnt   = 0;
            ack_slot  = 1'b0;
            drive_low = 1'b0;
        end else if (scl_d === 1'b1 && scl === 1'b1 && sda_d === 1'b0 && sda === 1'b1) begin
            phase     = sl_idle;                   // stop
            drive_low = 1'b0;
        end else if (scl_d === 1'b0 && scl === 1'b1) begin
            if (!ack_slot && phase != sl_idle && bit_cnt < 8) begin
                shreg   = {shreg[6:0], sda};       // msb first
                bit_cnt = bit_cnt + 1;
            end
        end else if (scl_d === 1'b1 && scl === 1'b0) begin
            scl_fall();
        end
        scl_d = scl;
        sda_d = sda;
    end

endmodule

`default_nettype wire

// File: design/i2c_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i2c_exec,
    input  logic        i2c_rh_wl,
    input  logic        bit_ctrl,
    input  logic [6:0]  sensor_addr,
    input  logic [15:0] i2c_addr,
    input  logic [7:0]  i2c_data_w,
    output logic [7:0]  i2c_data_r,
    output logic        i2c_done,
    output logic        err_flag,
    output logic        scl,
    inout  wire         sda
);

    logic busy;
    logic quarter_tick;
    logic sda_oe;
    logic sda_o;
    wire  sda_in;

    i2c_shift_if sh_if ();

    i2c_quarter_timer i_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy         (busy),
        .quarter_tick (quarter_tick)
    );

    i2c_byte_shifter i_shifter (
        .clk   (clk),
        .rst_n (rst_n),
        .sh    (sh_if.shifter)
    );

    i2c_sequencer i_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .exec         (i2c_exec),
        .rd           (i2c_rh_wl),
        .addr16       (bit_ctrl),
        .dev_addr     (sensor_addr),
        .reg_addr     (i2c_addr),
        .wr_data      (i2c_data_w),
        .quarter_tick (quarter_tick),
        .busy         (busy),
        .sh           (sh_if.seq),
        .sda_in       (sda_in),
        .scl          (scl),
        .sda_oe       (sda_oe),
        .sda_o        (sda_o),
        .done         (i2c_done),
        .err          (err_flag)
    );

    // open drain, pull low or let go
    assign sda    = (sda_oe && !sda_o) ? 1'b0 : 1'bz;
    assign sda_in = sda;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_data_r <= '0;
        end else if (i2c_done) begin
            i2c_data_r <= sh_if.data;    // holds until the next done
        end
    end

endmodule

`default_nettype wire

// File: design/i2c_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_sequencer
    import i2c_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exec,
    input  logic        rd,
    input  logic        addr16,
    input  logic [6:0]  dev_addr,
    input  logic [15:0] reg_addr,
    input  byte_t       wr_data,
    input  logic        quarter_tick,
    output logic        busy,
    i2c_shift_if.seq    sh,
    input  logic        sda_in,
    output logic        scl,
    output logic        sda_oe,
    output logic        sda_o,
    output logic        done,
    output logic        err
);

    i2c_state_e        state, state_nxt;
    logic [QCNT_W-1:0] qcnt;
    logic [QCNT_W-1:0] q_last;
    logic              phase_end;
    logic              tx_phase;
    logic              nack;
    logic              rd_q, addr16_q;
    logic [6:0]        dev_q;
    logic [15:0]       reg_q;
    byte_t             wdata_q;

    assign busy      = (state != st_idle);
    assign phase_end = quarter_tick && (qcnt == q_last);
    assign tx_phase  = (state == st_dev_addr) || (state == st_reg_addr_hi) ||
                       (state == st_reg_addr_lo) || (state == st_data_wr) ||
                       (state == st_dev_addr_rd);

    always_comb begin
        case (state)
            st_start:            q_last = QCNT_W'(QUARTERS_START - 1);
            st_restart, st_stop: q_last = QCNT_W'(QUARTERS_SHORT - 1);
            st_idle, st_error:   q_last = '0;
            default:             q_last = QCNT_W'(QUARTERS_BYTE - 1);
        endcase
    end

    // ============================================================
    // phase sequencing
    // ============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:        if (exec) state_nxt = st_start;
            st_start:       if (phase_end) state_nxt = st_dev_addr;
            st_dev_addr:    if (phase_end) state_nxt = nack ? st_error :
                                (addr16_q ? st_reg_addr_hi : st_reg_addr_lo);
            st_reg_addr_hi: if (phase_end) state_nxt = nack ? st_error : st_reg_addr_lo;
            st_reg_addr_lo: if (phase_end) state_nxt = nack ? st_error :
                                (rd_q ? st_restart : st_data_wr);
            st_data_wr:     if (phase_end) state_nxt = nack ? st_error : st_stop;
            st_restart:     if (phase_end) state_nxt = st_dev_addr_rd;
            st_dev_addr_rd: if (phase_end) state_nxt = nack ? st_error : st_data_rd;
            st_data_rd:     if (phase_end) state_nxt = st_stop;
            st_stop:        if (phase_end) state_nxt = st_idle;
            default:        state_nxt = st_idle;    // error lasts one clock
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            qcnt     <= '0;
            rd_q     <= 1'b0;
            addr16_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_idle && exec) begin
                rd_q     <= rd;
                addr16_q <= addr16;
            end
            if (!busy || state == st_error) begin
                qcnt <= '0;
            end else if (quarter_tick) begin
                qcnt <= phase_end ? '0 : qcnt + 1'b1;
            end
        end
    end

    // request fields, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == st_idle && exec) begin
            dev_q   <= dev_addr;
            reg_q   <= reg_addr;
            wdata_q <= wr_data;
        end
    end

    // ============================================================
    // byte shifter control
    // ============================================================
    always_comb begin
        sh.load      = 1'b0;
        sh.load_byte = '0;
        case (state_nxt)
            st_dev_addr:    sh.load_byte = {dev_q, 1'b0};
            st_reg_addr_hi: sh.load_byte = reg_q[15:8];
            st_reg_addr_lo: sh.load_byte = reg_q[7:0];
            st_data_wr:     sh.load_byte = wdata_q;
            st_dev_addr_rd: sh.load_byte = {dev_q, 1'b1};
            default:        sh.load_byte = '0;
        endcase
        if (phase_end &&
            (state_nxt == st_dev_addr || state_nxt == st_reg_addr_hi ||
             state_nxt == st_reg_addr_lo || state_nxt == st_data_wr ||
             state_nxt == st_dev_addr_rd)) begin
            sh.load = 1'b1;
        end
    end

    // send while scl is low, sample in the middle of scl high
    assign sh.shift_out = quarter_tick && tx_phase && (qcnt[1:0] == 2'd3) &&
                          (qcnt < ACK_QUARTER);
    assign sh.shift_in  = quarter_tick && (state == st_data_rd) &&
                          (qcnt[1:0] == 2'd1) && (qcnt < ACK_QUARTER);
    assign sh.in_bit    = sda_in;

    // ============================================================
    // bus drive
    // ============================================================
    always_comb begin
        sda_oe = 1'b0;
        sda_o  = 1'b1;
        case (state)
            st_start: begin
                sda_oe = 1'b1;
                sda_o  = (qcnt < 'd5);              // falls after quarter 4 while scl high
            end
            st_restart: begin
                sda_oe = 1'b1;
                sda_o  = (qcnt < 'd2);
            end
            st_stop: begin
                sda_oe = 1'b1;
                sda_o  = (qcnt >= 'd2);             // rises while scl high
            end
            st_data_rd: sda_oe = (qcnt >= ACK_QUARTER);  // nack bit driven high
            default: begin
                if (tx_phase) begin
                    sda_oe = (qcnt < ACK_QUARTER);  // released for slave ack
                    sda_o  = sh.msb;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl <= 1'b1;
        end else if (state == st_idle || state == st_error) begin
            scl <= 1'b1;
        end else if (quarter_tick) begin
            case (state)
                st_start: begin
                    if (qcnt == 'd1)
                        scl <= 1'b1;
                    else if (qcnt == 'd5)
                        scl <= 1'b0;
                end
                st_stop: if (qcnt == '0) scl <= 1'b1;   // stays high to the end
                default: begin
                    if (qcnt[1:0] == 2'd0)
                        scl <= 1'b1;
                    else if (qcnt[1:0] == 2'd2)
                        scl <= 1'b0;
                end
            endcase
        end
    end

    // ============================================================
    // ack and status
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nack <= 1'b0;
            done <= 1'b0;
            err  <= 1'b0;
        end else begin
            if (quarter_tick && tx_phase && qcnt == QCNT_W'(ACK_QUARTER + 1))
                nack <= sda_in;                     // high level means no ack
            done <= (state == st_stop) && phase_end;
            err  <= (state == st_error);
        end
    end

endmodule

`default_nettype wire

// File: design/i2c_byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_shifter
    import i2c_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    i2c_shift_if.shifter   sh
);

    byte_t sreg;

    // ============================================================
    // shift register
    // ============================================================
    // load wins over both shifts; the sequencer never asks for
    // shift_out and shift_in in the same phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sreg <= '0;
        end else if (sh.load) begin
            sreg <= sh.load_byte;                 // next byte at phase boundary
        end else if (sh.shift_out) begin
            sreg <= {sreg[6:0], 1'b0};            // next bit to msb
        end else if (sh.shift_in) begin
            sreg <= {sreg[6:0], sh.in_bit};       // msb first from the bus
        end
    end

    assign sh.msb  = sreg[7];
    assign sh.data = sreg;       // read data once data_rd is over

endmodule

`default_nettype wire

// File: design/i2c_quarter_timer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_quarter_timer
    import i2c_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic busy,
    output logic quarter_tick
);

    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_W'(QUARTER_DIV - 1));

    // ============================================================
    // quarter-bit divider
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt      <= '0;
            quarter_tick <= 1'b0;
        end else if (!busy) begin
            div_cnt      <= '0;        // restart phase alignment each transaction
            quarter_tick <= 1'b0;
        end else if (div_wrap) begin
            div_cnt      <= '0;
            quarter_tick <= 1'b1;      // one-cycle pulse
        end else begin
            div_cnt      <= div_cnt + 1'b1;
            quarter_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/i2c_shift_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i2c_shift_if
    import i2c_pkg::*;
();

    logic  load;       // take load_byte
    byte_t load_byte;
    logic  shift_out;  // shift left, zero fill
    logic  shift_in;   // shift left, take in_bit
    logic  in_bit;
    logic  msb;        // bit on the wire when sending
    byte_t data;

    modport seq (
        output load, load_byte, shift_out, shift_in, in_bit,
        input  msb, data
    );

    modport shifter (
        input  load, load_byte, shift_out, shift_in, in_bit,
        output msb, data
    );

endinterface

`default_nettype wire

// File: design/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // ============================================================
    // bus timing
    // ============================================================
    localparam int CLK_FREQ_HZ    = 50_000_000;                  // system clock
    localparam int SCL_FREQ_HZ    = 1_000_000;                   // scl rate
    localparam int QUARTER_DIV    = CLK_FREQ_HZ / SCL_FREQ_HZ / 4; // clocks per quarter, 12
    localparam int DIV_W          = $clog2(QUARTER_DIV);        // divider width

    // ============================================================
    // phase lengths in quarters
    // ============================================================
    localparam int QUARTERS_START = 7;
    localparam int QUARTERS_BYTE  = (8 + 1) * 4;    // 8 data bits + ack
    localparam int QUARTERS_SHORT = 4;              // repeated start, stop
    localparam int ACK_QUARTER    = 32;             // first quarter of ack bit
    localparam int QCNT_W         = 6;

    typedef logic [7:0] byte_t;

    // one-hot sequencer states
    typedef enum logic [10:0] {
        st_idle        = 11'b000_0000_0001,
        st_start       = 11'b000_0000_0010,
        st_dev_addr    = 11'b000_0000_0100,
        st_reg_addr_hi = 11'b000_0000_1000,
        st_reg_addr_lo = 11'b000_0001_0000,
        st_data_wr     = 11'b000_0010_0000,
        st_restart     = 11'b000_0100_0000,
        st_dev_addr_rd = 11'b000_1000_0000,
        st_data_rd     = 11'b001_0000_0000,
        st_stop        = 11'b010_0000_0000,
        st_error       = 11'b100_0000_0000
    } i2c_state_e;

endpackage

`default_nettype wire
